/* logic/mem_pkg.sv */
package mem_pkg;

  //////////////////////////////////////////////////
  // datapath widths
  //////////////////////////////////////////////////

  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;
  localparam int REG_WIDTH  = 5;

  localparam int STRB_WIDTH    = DATA_WIDTH / 8;        // one strobe per byte.
  localparam int BYTE_SEL_BITS = $clog2(STRB_WIDTH);    // byte within a word.

  //////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////

  localparam int LINE_BYTES = 16;
  localparam int LINE_WIDTH = LINE_BYTES * 8;
  localparam int N_LINES    = 4;

  localparam int OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int INDEX_BITS  = $clog2(N_LINES);
  localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
  localparam int WORD_BITS   = OFFSET_BITS - BYTE_SEL_BITS; // word within a line.

  //////////////////////////////////////////////////
  // access size of a load or store
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } access_size_t;

endpackage : mem_pkg

/* logic/dcache_cpu_if.sv */
`timescale 1ns/1ns

interface dcache_cpu_if import mem_pkg::*; ();

  // request side, driven by the pipeline.
  logic                  req;
  logic                  wr;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0] wstrb;

  // response side, driven by the cache.
  logic                  hit;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  done;

  modport core (
    output req, wr, addr, wdata, wstrb,
    input  hit, rdata, done
  );

  modport cache (
    input  req, wr, addr, wdata, wstrb,
    output hit, rdata, done
  );

endinterface : dcache_cpu_if

/* logic/line_bus_if.sv */
`timescale 1ns/1ns

interface line_bus_if import mem_pkg::*; ();

  logic                  mem_req;
  logic                  mem_we;
  logic [ADDR_WIDTH-1:0] mem_addr;   // line aligned.
  logic [LINE_WIDTH-1:0] mem_wdata;
  logic                  mem_gnt;
  logic                  mem_rvalid;
  logic [LINE_WIDTH-1:0] mem_rdata;
  logic                  mem_wr_done;

  modport cache (
    output mem_req, mem_we, mem_addr, mem_wdata,
    input  mem_gnt, mem_rvalid, mem_rdata, mem_wr_done
  );

  modport mem (
    input  mem_req, mem_we, mem_addr, mem_wdata,
    output mem_gnt, mem_rvalid, mem_rdata, mem_wr_done
  );

endinterface : line_bus_if

/* logic/data_cache.sv */
`timescale 1ns/1ns

module data_cache import mem_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_i,
  dcache_cpu_if.cache  cpu,
  line_bus_if.cache    mem,
  input  logic         flush_req_i,
  output logic         flush_ack_o
);

  typedef enum logic [2:0] {
    S_IDLE      = 3'd0,
    S_WB_REQ    = 3'd1,
    S_WB_WAIT   = 3'd2,
    S_FILL_REQ  = 3'd3,
    S_FILL_WAIT = 3'd4,
    S_DONE      = 3'd5,
    S_FL_SCAN   = 3'd6,
    S_FL_ACK    = 3'd7
  } state_t;

  state_t state_q, state_d;

  logic [N_LINES-1:0]    valid_q;
  logic [N_LINES-1:0]    dirty_q;
  logic [TAG_BITS-1:0]   tag_q  [N_LINES];
  logic [LINE_WIDTH-1:0] data_q [N_LINES];

  logic                  flushing_q;
  logic [INDEX_BITS-1:0] flush_idx_q;

  logic [TAG_BITS-1:0]   cpu_tag;
  logic [INDEX_BITS-1:0] cpu_idx;
  logic [WORD_BITS-1:0]  cpu_word;
  logic [INDEX_BITS-1:0] line_idx;
  logic [LINE_WIDTH-1:0] line_merged;
  logic                  store_en;
  logic                  fill_en;
  logic                  flush_start;
  logic                  flush_step;
  logic                  line_needs_wb;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  assign cpu_tag  = cpu.addr[ADDR_WIDTH-1 -: TAG_BITS];
  assign cpu_idx  = cpu.addr[OFFSET_BITS +: INDEX_BITS];
  assign cpu_word = cpu.addr[BYTE_SEL_BITS +: WORD_BITS];

  // line under write-back, victim or flush target.
  assign line_idx      = flushing_q ? flush_idx_q : cpu_idx;
  assign line_needs_wb = valid_q[line_idx] && dirty_q[line_idx];

  assign cpu.hit   = (state_q == S_IDLE) && cpu.req && valid_q[cpu_idx] &&
                     (tag_q[cpu_idx] == cpu_tag);
  assign cpu.rdata = data_q[cpu_idx][cpu_word*DATA_WIDTH +: DATA_WIDTH];
  assign cpu.done  = (state_q == S_DONE);

  always_comb begin
    line_merged = data_q[cpu_idx];
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (cpu.wstrb[b]) begin
        line_merged[cpu_word*DATA_WIDTH + b*8 +: 8] = cpu.wdata[b*8 +: 8];
      end
    end
  end

  assign store_en = cpu.req && cpu.wr &&
                    ((state_q == S_IDLE && cpu.hit) || state_q == S_DONE);
  assign fill_en  = (state_q == S_FILL_WAIT) && mem.mem_rvalid;

  assign flush_start = (state_q == S_IDLE) && !cpu.req && flush_req_i;
  assign flush_step  = (state_q == S_FL_SCAN) && !line_needs_wb &&
                       (flush_idx_q != INDEX_BITS'(N_LINES - 1));

  //////////////////////////////////////////////////
  // memory bus
  //////////////////////////////////////////////////

  assign mem.mem_req   = (state_q == S_WB_REQ) || (state_q == S_FILL_REQ);
  assign mem.mem_we    = (state_q == S_WB_REQ);
  assign mem.mem_wdata = data_q[line_idx];

  always_comb begin
    if (state_q == S_FILL_REQ) begin
      mem.mem_addr = {cpu_tag, cpu_idx, {OFFSET_BITS{1'b0}}};
    end else begin
      mem.mem_addr = {tag_q[line_idx], line_idx, {OFFSET_BITS{1'b0}}}; // victim address.
    end
  end

  assign flush_ack_o = (state_q == S_FL_ACK);

  //////////////////////////////////////////////////
  // controller
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (cpu.req && !cpu.hit) begin
          state_d = line_needs_wb ? S_WB_REQ : S_FILL_REQ;
        end else if (flush_start) begin
          state_d = S_FL_SCAN;
        end
      end
      S_WB_REQ: begin
        if (mem.mem_gnt) state_d = S_WB_WAIT;
      end
      S_WB_WAIT: begin
        if (mem.mem_wr_done) state_d = flushing_q ? S_FL_SCAN : S_FILL_REQ;
      end
      S_FILL_REQ: begin
        if (mem.mem_gnt) state_d = S_FILL_WAIT;
      end
      S_FILL_WAIT: begin
        if (mem.mem_rvalid) state_d = S_DONE;
      end
      S_DONE: begin
        state_d = S_IDLE;
      end
      S_FL_SCAN: begin
        if (line_needs_wb) begin
          state_d = S_WB_REQ;
        end else if (flush_idx_q == INDEX_BITS'(N_LINES - 1)) begin
          state_d = S_FL_ACK;
        end
      end
      S_FL_ACK: begin
        if (!flush_req_i) state_d = S_IDLE;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q     <= S_IDLE;
      valid_q     <= '0;
      dirty_q     <= '0;
      flushing_q  <= 1'b0;
      flush_idx_q <= '0;
    end else begin
      state_q <= state_d;
      if (store_en) dirty_q[cpu_idx] <= 1'b1;
      if (state_q == S_WB_WAIT && mem.mem_wr_done) dirty_q[line_idx] <= 1'b0;
      if (fill_en) begin
        valid_q[cpu_idx] <= 1'b1;
        dirty_q[cpu_idx] <= 1'b0;                 // fresh line is clean.
      end
      if (flush_start) begin
        flushing_q  <= 1'b1;
        flush_idx_q <= '0;
      end
      if (flush_step) flush_idx_q <= flush_idx_q + 1'b1;
      if (state_q == S_FL_ACK && !flush_req_i) flushing_q <= 1'b0;
    end
  end

  // line storage.
  always_ff @(posedge clk_i) begin
    if (fill_en) begin
      data_q[cpu_idx] <= mem.mem_rdata;
      tag_q[cpu_idx]  <= cpu_tag;
    end else if (store_en) begin
      data_q[cpu_idx] <= line_merged;
    end
  end

endmodule : data_cache

/* logic/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage import mem_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic                  is_load_i,
  input  logic                  is_store_i,
  input  logic                  reg_wr_en_i,
  input  access_size_t          access_size_i,
  input  logic [DATA_WIDTH-1:0] alu_result_i,
  input  logic [DATA_WIDTH-1:0] rs2_data_i,
  input  logic [REG_WIDTH-1:0]  wr_reg_i,
  dcache_cpu_if.core            cpu,
  output logic                  wb_valid_o,
  output logic                  wb_reg_wr_en_o,
  output logic                  stall_o,
  output logic [REG_WIDTH-1:0]  wb_wr_reg_o,
  output logic [DATA_WIDTH-1:0] wb_data_o
);

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_READY   = 2'd1,
    ST_WAITING = 2'd2
  } state_t;

  state_t state_q, state_d;

  logic                     is_mem;
  logic [BYTE_SEL_BITS-1:0] byte_off;
  logic [DATA_WIDTH-1:0]    load_shifted;
  logic [DATA_WIDTH-1:0]    load_data;

  assign is_mem   = is_load_i | is_store_i;
  assign byte_off = alu_result_i[BYTE_SEL_BITS-1:0];

  //////////////////////////////////////////////////
  // request to the cache
  //////////////////////////////////////////////////

  assign cpu.wr    = is_store_i;
  assign cpu.addr  = alu_result_i;
  assign cpu.wdata = rs2_data_i << {byte_off, 3'b000}; // move into its lane.

  always_comb begin
    case (access_size_i)
      BYTE:    cpu.wstrb = STRB_WIDTH'(4'b0001) << byte_off;
      HALF:    cpu.wstrb = STRB_WIDTH'(4'b0011) << byte_off;
      default: cpu.wstrb = '1;
    endcase
  end

  //////////////////////////////////////////////////
  // load alignment and write-back record
  //////////////////////////////////////////////////

  assign load_shifted = cpu.rdata >> {byte_off, 3'b000};

  always_comb begin
    case (access_size_i)
      BYTE:    load_data = {{(DATA_WIDTH-8){1'b0}}, load_shifted[7:0]};
      HALF:    load_data = {{(DATA_WIDTH-16){1'b0}}, load_shifted[15:0]};
      default: load_data = cpu.rdata;
    endcase
  end

  assign wb_data_o      = is_load_i ? load_data : alu_result_i;
  assign wb_reg_wr_en_o = is_load_i | reg_wr_en_i;   // loads always write.
  assign wb_wr_reg_o    = wr_reg_i;

  //////////////////////////////////////////////////
  // controller
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    cpu.req    = 1'b0;
    wb_valid_o = 1'b0;
    stall_o    = 1'b0;
    case (state_q)
      ST_IDLE: begin
        stall_o = valid_i;
        state_d = ST_READY;
      end
      ST_READY: begin
        if (valid_i) begin
          if (!is_mem) begin
            wb_valid_o = 1'b1;
          end else begin
            cpu.req = 1'b1;
            if (cpu.hit) begin
              wb_valid_o = 1'b1;
            end else begin
              stall_o = 1'b1;
              state_d = ST_WAITING;
            end
          end
        end
      end
      ST_WAITING: begin
        cpu.req = 1'b1;                          // held until the fill is done.
        if (cpu.done) begin
          wb_valid_o = 1'b1;
          state_d    = ST_READY;
        end else begin
          stall_o = 1'b1;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule : mem_stage

/* logic/lsu_mem_top.sv */
`timescale 1ns/1ns

module lsu_mem_top import mem_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic                  is_load_i,
  input  logic                  is_store_i,
  input  logic                  reg_wr_en_i,
  input  access_size_t          access_size_i,
  input  logic [DATA_WIDTH-1:0] alu_result_i,
  input  logic [DATA_WIDTH-1:0] rs2_data_i,
  input  logic [REG_WIDTH-1:0]  wr_reg_i,
  output logic                  wb_valid_o,
  output logic                  wb_reg_wr_en_o,
  output logic                  stall_o,
  output logic [REG_WIDTH-1:0]  wb_wr_reg_o,
  output logic [DATA_WIDTH-1:0] wb_data_o,
  input  logic                  flush_req_i,
  output logic                  flush_ack_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [ADDR_WIDTH-1:0] mem_addr_o,
  output logic [LINE_WIDTH-1:0] mem_wdata_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  logic [LINE_WIDTH-1:0] mem_rdata_i,
  input  logic                  mem_wr_done_i
);

  dcache_cpu_if u_cpu_if ();
  line_bus_if   u_mem_bus ();

  mem_stage u_mem_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (valid_i),
    .is_load_i      (is_load_i),
    .is_store_i     (is_store_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .access_size_i  (access_size_i),
    .alu_result_i   (alu_result_i),
    .rs2_data_i     (rs2_data_i),
    .wr_reg_i       (wr_reg_i),
    .cpu            (u_cpu_if.core),
    .wb_valid_o     (wb_valid_o),
    .wb_reg_wr_en_o (wb_reg_wr_en_o),
    .stall_o        (stall_o),
    .wb_wr_reg_o    (wb_wr_reg_o),
    .wb_data_o      (wb_data_o)
  );

  data_cache u_data_cache (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cpu         (u_cpu_if.cache),
    .mem         (u_mem_bus.cache),
    .flush_req_i (flush_req_i),
    .flush_ack_o (flush_ack_o)
  );

  // line bus out to the pins.
  assign mem_req_o               = u_mem_bus.mem_req;
  assign mem_we_o                = u_mem_bus.mem_we;
  assign mem_addr_o              = u_mem_bus.mem_addr;
  assign mem_wdata_o             = u_mem_bus.mem_wdata;
  assign u_mem_bus.mem_gnt       = mem_gnt_i;
  assign u_mem_bus.mem_rvalid    = mem_rvalid_i;
  assign u_mem_bus.mem_rdata     = mem_rdata_i;
  assign u_mem_bus.mem_wr_done   = mem_wr_done_i;

endmodule : lsu_mem_top

/* sim/lsu_mem_assertions.sv */
`timescale 1ns/1ns

module lsu_mem_assertions import mem_pkg::*; (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  valid_i,
  input logic                  stall_o,
  input logic                  wb_valid_o,
  input logic                  flush_req_i,
  input logic                  flush_ack_o,
  input logic                  mem_req_o,
  input logic                  mem_we_o,
  input logic [ADDR_WIDTH-1:0] mem_addr_o,
  input logic                  mem_gnt_i
);

  // request held stable until granted.
  assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o))
    else $error("mem_req_o or its address changed before mem_gnt_i");

  assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_o && mem_gnt_i |=> !mem_req_o)
    else $error("mem_req_o did not drop after the grant");

  // a stall ends only by completing the operation.
  assert property (@(posedge clk_i) disable iff (!rst_i) stall_o |=> stall_o || wb_valid_o)
    else $error("stall_o fell without a write-back record");

  assert property (@(posedge clk_i) disable iff (!rst_i) stall_o |-> valid_i)
    else $error("stall_o raised without a valid operation");

  // four-phase flush acknowledge.
  assert property (@(posedge clk_i) disable iff (!rst_i)
    flush_ack_o && flush_req_i |=> flush_ack_o)
    else $error("flush_ack_o fell while flush_req_i is still high");

  assert property (@(posedge clk_i) disable iff (!rst_i)
    flush_ack_o && !flush_req_i |=> !flush_ack_o)
    else $error("flush_ack_o stayed high after flush_req_i fell");

endmodule : lsu_mem_assertions

/* sim/lsu_mem_tb.sv */
`timescale 1ns/1ns

module lsu_mem_tb import mem_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 5;
  localparam int SEED         = 2;
  localparam int MAX_OPS      = 64;
  localparam int OP_CYCLES    = 40;
  localparam int FLUSH_CYCLES = N_LINES * 40;
  localparam int MEM_BYTES    = 256;
  localparam int OP_BITS      = 84;  // kind, size, hit, addr, data, reg.

  localparam logic [3:0] K_ALU    = 4'h0;
  localparam logic [3:0] K_ALU_WR = 4'h1;
  localparam logic [3:0] K_LOAD   = 4'h2;
  localparam logic [3:0] K_STORE  = 4'h3;
  localparam logic [3:0] K_END    = 4'hf;

  logic                  clk_i;
  logic                  rst_i;
  logic                  valid_i;
  logic                  is_load_i;
  logic                  is_store_i;
  logic                  reg_wr_en_i;
  access_size_t          access_size_i;
  logic [DATA_WIDTH-1:0] alu_result_i;
  logic [DATA_WIDTH-1:0] rs2_data_i;
  logic [REG_WIDTH-1:0]  wr_reg_i;
  logic                  wb_valid_o;
  logic                  wb_reg_wr_en_o;
  logic                  stall_o;
  logic [REG_WIDTH-1:0]  wb_wr_reg_o;
  logic [DATA_WIDTH-1:0] wb_data_o;
  logic                  flush_req_i;
  logic                  flush_ack_o;
  logic                  mem_req_o;
  logic                  mem_we_o;
  logic [ADDR_WIDTH-1:0] mem_addr_o;
  logic [LINE_WIDTH-1:0] mem_wdata_o;
  logic                  mem_gnt_i;
  logic                  mem_rvalid_i;
  logic [LINE_WIDTH-1:0] mem_rdata_i;
  logic                  mem_wr_done_i;

  logic [OP_BITS-1:0] ops [MAX_OPS];
  logic [7:0]         model_mem  [MEM_BYTES];
  logic [7:0]         shadow_mem [MEM_BYTES];
  int                 n_ops;
  int                 wb_count;

  lsu_mem_top u_dut (.*);

  bind lsu_mem_top lsu_mem_assertions u_assertions (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check(input logic [LINE_WIDTH-1:0] actual,
                       input logic [LINE_WIDTH-1:0] expected, input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
               $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  function automatic logic [LINE_WIDTH-1:0] shadow_line(input logic [7:0] base);
    logic [LINE_WIDTH-1:0] line;
    for (int b = 0; b < LINE_BYTES; b++) line[b*8 +: 8] = shadow_mem[base + b];
    return line;
  endfunction

  //////////////////////////////////////////////////
  // line memory with random latencies
  //////////////////////////////////////////////////

  initial begin : line_memory
    logic                  we;
    logic [7:0]            base;
    logic [LINE_WIDTH-1:0] wdata;
    logic [LINE_WIDTH-1:0] line;
    int unsigned           delay;
    void'($urandom(SEED));
    forever begin
      @(negedge clk_i);
      if (rst_i && mem_req_o) begin
        we    = mem_we_o;
        base  = mem_addr_o[7:0];
        wdata = mem_wdata_o;
        delay = $urandom % 8;
        repeat (delay + 1) begin
          @(posedge clk_i);
          #DRIVE_DELAY;
        end
        mem_gnt_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DELAY;
        mem_gnt_i = 1'b0;
        delay = $urandom % 8;
        repeat (delay) begin
          @(posedge clk_i);
          #DRIVE_DELAY;
        end
        if (we) begin
          check(wdata, shadow_line(base), "victim line on the bus");
          for (int b = 0; b < LINE_BYTES; b++) model_mem[base + b] = wdata[b*8 +: 8];
          mem_wr_done_i = 1'b1;
        end else begin
          for (int b = 0; b < LINE_BYTES; b++) line[b*8 +: 8] = model_mem[base + b];
          mem_rdata_i  = line;
          mem_rvalid_i = 1'b1;
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        mem_wr_done_i = 1'b0;
        mem_rvalid_i  = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // operations and flush
  //////////////////////////////////////////////////

  task automatic run_op(input logic [OP_BITS-1:0] op);
    logic [3:0]  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expect_load;
    int          a;
    int          n_bytes;
    int          cycles;
    kind    = op[83:80];
    addr    = op[71:40];
    data    = op[39:8];
    a       = addr[7:0];
    n_bytes = 1 << op[77:76];
    @(posedge clk_i);
    #DRIVE_DELAY;
    valid_i       = 1'b1;
    is_load_i     = (kind == K_LOAD);
    is_store_i    = (kind == K_STORE);
    reg_wr_en_i   = (kind == K_ALU_WR);
    access_size_i = access_size_t'(op[77:76]);
    alu_result_i  = addr;
    rs2_data_i    = (kind == K_STORE) ? data : 32'h0;
    wr_reg_i      = op[REG_WIDTH-1:0];
    cycles        = 0;
    do begin
      @(negedge clk_i);
      cycles++;
      if (!wb_valid_o) check(stall_o, 1'b1, "stall_o while the operation waits");
    end while (!wb_valid_o);  // inputs held through the stall.
    check(stall_o, 1'b0, "stall_o at completion");
    check(wb_wr_reg_o, op[REG_WIDTH-1:0], "wb_wr_reg_o");
    check(wb_reg_wr_en_o, (kind == K_ALU_WR) || (kind == K_LOAD), "wb_reg_wr_en_o");
    if (op[72]) check(cycles, 1, "cycles for a hit or non-memory op");
    else check(cycles > 1, 1'b1, "a miss completed without stalling");
    if (kind == K_LOAD) begin
      expect_load = '0;
      for (int b = 0; b < n_bytes; b++) expect_load[b*8 +: 8] = shadow_mem[a + b];
      check(wb_data_o, data, "load data against file");
      check(wb_data_o, expect_load, "load data against shadow memory");
    end else begin
      check(wb_data_o, addr, "wb_data_o of a non-load");
    end
    if (kind == K_STORE) begin
      for (int b = 0; b < n_bytes; b++) shadow_mem[a + b] = data[b*8 +: 8];
    end
  endtask

  task automatic run_flush();
    @(posedge clk_i);
    #DRIVE_DELAY;
    valid_i     = 1'b0;
    flush_req_i = 1'b1;
    do @(negedge clk_i); while (!flush_ack_o);
    for (int a = 0; a < MEM_BYTES; a++) check(model_mem[a], shadow_mem[a], "memory after flush");
    @(posedge clk_i);
    #DRIVE_DELAY;
    flush_req_i = 1'b0;
    @(negedge clk_i);
    check(flush_ack_o, 1'b1, "flush_ack_o in the release cycle");
    @(negedge clk_i);
    check(flush_ack_o, 1'b0, "flush_ack_o after release");
  endtask

  always @(negedge clk_i) begin
    if (rst_i && wb_valid_o) wb_count++;
  end

  initial begin
    wait (rst_i === 1'b1);
    #((n_ops * OP_CYCLES + FLUSH_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before all operations and the flush completed");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    rst_i         = 1'b0;
    valid_i       = 1'b0;
    is_load_i     = 1'b0;
    is_store_i    = 1'b0;
    reg_wr_en_i   = 1'b0;
    access_size_i = WORD;
    alu_result_i  = '0;
    rs2_data_i    = '0;
    wr_reg_i      = '0;
    flush_req_i   = 1'b0;
    mem_gnt_i     = 1'b0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    mem_wr_done_i = 1'b0;
    wb_count      = 0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      model_mem[a]  = 8'(a) ^ 8'ha5;
      shadow_mem[a] = 8'(a) ^ 8'ha5;
    end
    for (int i = 0; i < MAX_OPS; i++) ops[i] = '1;
    $readmemh("sim/lsu_mem_input.txt", ops);
    n_ops = 0;
    while (n_ops < MAX_OPS && ops[n_ops][83:80] != K_END) n_ops++;
    if (n_ops == 0) begin
      $display("no operations were read from the stimulus file");
      $display("TEST FAILED");
      $fatal(1, "empty stimulus");
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b1;
    for (int i = 0; i < n_ops; i++) run_op(ops[i]);
    run_flush();
    check(wb_count, n_ops, "number of write-back records");
    $display("TEST OK");
    $finish;
  end

endmodule : lsu_mem_tb

/* sim/lsu_mem_input.txt */
// kind_size_hit_address_data_reg, data is store data or expected load data
// kind 0 alu, 1 alu with reg write, 2 load, 3 store, f end; size 0 byte 1 half 2 word
3_2_0_00000000_deadbeef_00
2_2_1_00000000_deadbeef_05
1_2_1_12345678_00000000_07
0_0_1_cafef00d_00000000_1f
3_0_1_00000002_123456ab_00
3_1_1_00000006_55aa1234_00
2_2_1_00000000_deabbeef_01
2_0_1_00000003_000000de_02
2_1_1_00000002_0000deab_03
2_2_1_00000004_1234a0a1_04
2_1_1_00000006_00001234_06
2_0_1_00000005_000000a0_08
3_2_0_00000040_0badf00d_00
2_2_1_00000040_0badf00d_09
2_2_0_00000000_deabbeef_0a
2_2_0_00000080_26272425_0b
2_2_0_00000044_e2e3e0e1_0c
2_2_1_00000040_0badf00d_0d
3_0_0_0000001d_00000077_00
3_1_0_0000005e_0000beef_00
2_0_0_0000001d_00000077_0e
2_2_0_00000020_86878485_0f
3_2_0_000000f0_13579bdf_11
1_0_1_00000000_00000000_12
f_0_0_00000000_00000000_00

/* lsu_mem_top.f */
logic/mem_pkg.sv
logic/dcache_cpu_if.sv
logic/line_bus_if.sv
logic/data_cache.sv
logic/mem_stage.sv
logic/lsu_mem_top.sv
sim/lsu_mem_assertions.sv
sim/lsu_mem_tb.sv
